// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [3:0]      reg_idx_t;
    typedef logic [xlen-1:0] word_t;

    localparam word_t reset_vector = 32'h0000_0000;

    // Machine-mode CSR addresses
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    localparam word_t cause_ecall_m = 32'd11;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b,
        alu_beq,
        alu_bne,
        alu_blt,
        alu_bge,
        alu_bltu,
        alu_bgeu
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        word_t       pc;
        word_t       rs1_val;
        word_t       rs2_val;
        word_t       imm;
        reg_idx_t    rd;
        logic        rd_we;
        alu_op_e     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        is_jal;
        logic        is_jalr;
        logic        is_branch;
        logic        is_csrrw;
        logic        is_csrrs;
        logic [11:0] csr_addr;
        logic        is_ecall;
        logic        is_mret;
        logic        is_ebreak;
        logic        illegal;
    } exec_pkt_t;

endpackage

`default_nettype wire

// File: pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      flush,
    input  wire      in_valid,
    output logic     in_ready,
    input  wire      payload_t in_data,
    output logic     out_valid,
    input  wire      out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // The slot can take a new entry when empty or when its entry leaves now
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (flush) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit
    import rv_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    output word_t      imem_addr,
    input  wire word_t imem_data,
    input  wire        imem_valid,
    output logic       out_valid,
    input  wire        out_ready,
    output fetch_pkt_t out_pkt,
    input  wire        redirect,
    input  wire word_t redirect_pc,
    input  wire        halt
);

    word_t pc_q;

    assign imem_addr = pc_q;

    // A word on the wrong path is dropped while execute redirects
    assign out_valid   = imem_valid && !redirect && !halt;
    assign out_pkt.pc   = pc_q;
    assign out_pkt.inst = imem_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= reset_vector;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (out_valid && out_ready) begin
            pc_q <= pc_q + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: decode_unit.sv
`default_nettype none

module decode_unit
    import rv_pkg::*;
(
    input  wire           in_valid,
    output logic          in_ready,
    input  wire fetch_pkt_t in_pkt,
    output logic          out_valid,
    input  wire           out_ready,
    output exec_pkt_t     out_pkt,
    output reg_idx_t      rs1_idx,
    output reg_idx_t      rs2_idx,
    input  wire word_t    rs1_data,
    input  wire word_t    rs2_data,
    input  wire           ex_valid,
    input  wire reg_idx_t ex_rd,
    input  wire           ex_rd_we
);

    word_t      inst;
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       known;
    logic       uses_rd;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       stall;

    // Register and immediate ALU ops share the funct3 mapping
    function automatic alu_op_e alu_from_f3(input logic [2:0] fn, input logic alt);
        alu_op_e op;
        case (fn)
            3'd0:    op = alt ? alu_sub : alu_add;
            3'd1:    op = alu_sll;
            3'd2:    op = alu_slt;
            3'd3:    op = alu_sltu;
            3'd4:    op = alu_xor;
            3'd5:    op = alt ? alu_sra : alu_srl;
            3'd6:    op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign inst   = in_pkt.inst;
    assign opcode = inst[6:0];
    assign f3     = inst[14:12];
    assign f7     = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // RV32E only has x0..x15, so bit 4 of a used index is dropped here
    assign rs1_idx = inst[18:15];
    assign rs2_idx = inst[23:20];

    always_comb begin
        known    = 1'b0;
        uses_rd  = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        out_pkt         = '0;
        out_pkt.pc      = in_pkt.pc;
        out_pkt.rs1_val = rs1_data;
        out_pkt.rs2_val = rs2_data;
        out_pkt.rd      = inst[10:7];
        out_pkt.alu_op  = alu_add;
        case (opcode)
            7'h33: begin
                known    = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                uses_rd  = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                out_pkt.alu_op = alu_from_f3(f3, f7[5]);
            end
            7'h13: begin
                if (f3 == 3'd1) begin
                    known = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    known = (f7 == 7'h00) || (f7 == 7'h20);
                end else begin
                    known = 1'b1;
                end
                uses_rd  = 1'b1;
                uses_rs1 = 1'b1;
                out_pkt.alu_op      = alu_from_f3(f3, (f3 == 3'd5) && f7[5]);
                out_pkt.imm         = imm_i;
                out_pkt.src2_is_imm = 1'b1;
            end
            7'h37, 7'h17: begin
                known   = 1'b1;
                uses_rd = 1'b1;
                out_pkt.alu_op      = opcode[5] ? alu_pass_b : alu_add;
                out_pkt.src1_is_pc  = !opcode[5];
                out_pkt.src2_is_imm = 1'b1;
                out_pkt.imm         = imm_u;
            end
            7'h6f: begin
                known   = 1'b1;
                uses_rd = 1'b1;
                out_pkt.is_jal      = 1'b1;
                out_pkt.src1_is_pc  = 1'b1;
                out_pkt.src2_is_imm = 1'b1;
                out_pkt.imm         = imm_j;
            end
            7'h67: begin
                known    = (f3 == 3'd0);
                uses_rd  = 1'b1;
                uses_rs1 = 1'b1;
                out_pkt.is_jalr     = 1'b1;
                out_pkt.src2_is_imm = 1'b1;
                out_pkt.imm         = imm_i;
            end
            7'h63: begin
                known    = (f3 != 3'd2) && (f3 != 3'd3);
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                out_pkt.is_branch = 1'b1;
                out_pkt.imm       = imm_b;
                case (f3)
                    3'd0:    out_pkt.alu_op = alu_beq;
                    3'd1:    out_pkt.alu_op = alu_bne;
                    3'd4:    out_pkt.alu_op = alu_blt;
                    3'd5:    out_pkt.alu_op = alu_bge;
                    3'd6:    out_pkt.alu_op = alu_bltu;
                    default: out_pkt.alu_op = alu_bgeu;
                endcase
            end
            7'h73: begin
                out_pkt.csr_addr = inst[31:20];
                if (f3 == 3'd1 || f3 == 3'd2) begin
                    known    = 1'b1;
                    uses_rd  = 1'b1;
                    uses_rs1 = 1'b1;
                    out_pkt.is_csrrw = (f3 == 3'd1);
                    out_pkt.is_csrrs = (f3 == 3'd2);
                end else if (f3 == 3'd0 && inst[19:7] == 13'd0) begin
                    out_pkt.is_ecall  = (inst[31:20] == 12'h000);
                    out_pkt.is_ebreak = (inst[31:20] == 12'h001);
                    out_pkt.is_mret   = (inst[31:20] == 12'h302);
                    known = out_pkt.is_ecall || out_pkt.is_ebreak || out_pkt.is_mret;
                end
            end
            default: ;
        endcase
        out_pkt.rd_we   = uses_rd;
        out_pkt.illegal = !known || (uses_rd && inst[11]) || (uses_rs1 && inst[19]) ||
                          (uses_rs2 && inst[24]);
    end

    // Hold the instruction until an older write to one of its sources has retired
    assign stall = ex_valid && ex_rd_we && (ex_rd != 4'd0) &&
                   ((uses_rs1 && rs1_idx == ex_rd) || (uses_rs2 && rs2_idx == ex_rd));

    assign out_valid = in_valid && !stall;
    assign in_ready  = out_ready && !stall;

endmodule

`default_nettype wire

// File: gpr_file.sv
`default_nettype none

module gpr_file
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire reg_idx_t rs1_idx,
    input  wire reg_idx_t rs2_idx,
    output word_t         rs1_data,
    output word_t         rs2_data,
    input  wire           we,
    input  wire reg_idx_t rd,
    input  wire word_t    wdata
);

    word_t regs [16];

    // x0 is cleared by reset and never written
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 4'd0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: csr_file.sv
`default_nettype none

module csr_file
    import rv_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire [11:0] addr,
    output word_t      rdata,
    input  wire        we,
    input  wire word_t wdata,
    input  wire        trap,
    input  wire word_t trap_pc,
    output word_t      mtvec,
    output word_t      mepc
);

    word_t mstatus_q;
    word_t mtvec_q;
    word_t mepc_q;
    word_t mcause_q;

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

    always_comb begin
        case (addr)
            csr_mstatus: rdata = mstatus_q;
            csr_mtvec:   rdata = mtvec_q;
            csr_mepc:    rdata = mepc_q;
            csr_mcause:  rdata = mcause_q;
            default:     rdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap) begin
            mepc_q   <= trap_pc;
            mcause_q <= cause_ecall_m;
        end else if (we) begin
            case (addr)
                csr_mstatus: mstatus_q <= wdata;
                csr_mtvec:   mtvec_q   <= wdata;
                csr_mepc:    mepc_q    <= wdata;
                csr_mcause:  mcause_q  <= wdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: exec_unit.sv
`default_nettype none

module exec_unit
    import rv_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            in_valid,
    output logic           in_ready,
    input  wire exec_pkt_t in_pkt,
    output logic           gpr_we,
    output reg_idx_t       gpr_rd,
    output word_t          gpr_wdata,
    output logic [11:0]    csr_addr,
    input  wire word_t     csr_rdata,
    output logic           csr_we,
    output word_t          csr_wdata,
    output logic           csr_trap,
    input  wire word_t     csr_mtvec,
    input  wire word_t     csr_mepc,
    output logic           redirect,
    output word_t          redirect_pc,
    output logic           retire_valid,
    output word_t          retire_pc,
    output logic           illegal,
    output logic           halt
);

    logic  halt_q;
    logic  fire;
    logic  live;
    logic  take;
    logic  is_csr;
    word_t op_a;
    word_t op_b;
    word_t alu_res;

    assign op_a = in_pkt.src1_is_pc ? in_pkt.pc : in_pkt.rs1_val;
    assign op_b = in_pkt.src2_is_imm ? in_pkt.imm : in_pkt.rs2_val;

    always_comb begin
        alu_res = '0;
        take    = 1'b0;
        case (in_pkt.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_slt:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu:   alu_res = word_t'(op_a < op_b);
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            alu_sll:    alu_res = op_a << op_b[4:0];
            alu_srl:    alu_res = op_a >> op_b[4:0];
            alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
            alu_pass_b: alu_res = op_b;
            alu_beq:    take = (op_a == op_b);
            alu_bne:    take = (op_a != op_b);
            alu_blt:    take = ($signed(op_a) < $signed(op_b));
            alu_bge:    take = ($signed(op_a) >= $signed(op_b));
            alu_bltu:   take = (op_a < op_b);
            alu_bgeu:   take = (op_a >= op_b);
            default: ;
        endcase
    end

    // An illegal instruction retires but has no other effect
    assign fire   = in_valid && !halt_q;
    assign live   = fire && !in_pkt.illegal;
    assign is_csr = in_pkt.is_csrrw || in_pkt.is_csrrs;

    assign in_ready     = !halt_q;
    assign retire_valid = fire;
    assign retire_pc    = in_pkt.pc;
    assign illegal      = fire && in_pkt.illegal;
    assign halt         = halt_q;

    assign gpr_we = live && in_pkt.rd_we;
    assign gpr_rd = in_pkt.rd;
    assign gpr_wdata = (in_pkt.is_jal || in_pkt.is_jalr) ? in_pkt.pc + 32'd4 :
                       is_csr ? csr_rdata : alu_res;

    assign csr_addr  = in_pkt.csr_addr;
    assign csr_we    = live && (in_pkt.is_csrrw || (in_pkt.is_csrrs && in_pkt.rs1_val != '0));
    assign csr_wdata = in_pkt.is_csrrw ? in_pkt.rs1_val : csr_rdata | in_pkt.rs1_val;
    assign csr_trap  = live && in_pkt.is_ecall;

    assign redirect = live && (in_pkt.is_jal || in_pkt.is_jalr || in_pkt.is_ecall ||
                               in_pkt.is_mret || (in_pkt.is_branch && take));

    always_comb begin
        if (in_pkt.is_ecall) begin
            redirect_pc = csr_mtvec;
        end else if (in_pkt.is_mret) begin
            redirect_pc = csr_mepc;
        end else if (in_pkt.is_jalr) begin
            redirect_pc = (in_pkt.rs1_val + in_pkt.imm) & ~word_t'(1);
        end else begin
            redirect_pc = in_pkt.pc + in_pkt.imm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halt_q <= 1'b0;
        end else if (live && in_pkt.is_ebreak) begin
            halt_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    output word_t      imem_addr,
    input  wire word_t imem_data,
    input  wire        imem_valid,
    output logic       retire_valid,
    output word_t      retire_pc,
    output reg_idx_t   retire_rd,
    output logic       retire_we,
    output word_t      retire_data,
    output logic       illegal,
    output logic       halt
);

    logic        f_valid;
    logic        f_ready;
    fetch_pkt_t  f_pkt;
    logic        d_in_valid;
    logic        d_in_ready;
    fetch_pkt_t  d_in_pkt;
    logic        d_out_valid;
    logic        d_out_ready;
    exec_pkt_t   d_out_pkt;
    logic        e_valid;
    logic        e_ready;
    exec_pkt_t   e_pkt;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    word_t       rs1_data;
    word_t       rs2_data;
    logic [11:0] csr_addr;
    word_t       csr_rdata;
    logic        csr_we;
    word_t       csr_wdata;
    logic        csr_trap;
    word_t       csr_mtvec;
    word_t       csr_mepc;
    logic        redirect;
    word_t       redirect_pc;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_data(imem_data), .imem_valid(imem_valid),
        .out_valid(f_valid), .out_ready(f_ready), .out_pkt(f_pkt),
        .redirect(redirect), .redirect_pc(redirect_pc), .halt(halt)
    );

    pipe_stage #(.payload_t(fetch_pkt_t)) u_fd (
        .clk(clk), .rst(rst), .flush(redirect),
        .in_valid(f_valid), .in_ready(f_ready), .in_data(f_pkt),
        .out_valid(d_in_valid), .out_ready(d_in_ready), .out_data(d_in_pkt)
    );

    decode_unit u_decode (
        .in_valid(d_in_valid), .in_ready(d_in_ready), .in_pkt(d_in_pkt),
        .out_valid(d_out_valid), .out_ready(d_out_ready), .out_pkt(d_out_pkt),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_valid(e_valid), .ex_rd(e_pkt.rd), .ex_rd_we(e_pkt.rd_we)
    );

    pipe_stage #(.payload_t(exec_pkt_t)) u_de (
        .clk(clk), .rst(rst), .flush(redirect),
        .in_valid(d_out_valid), .in_ready(d_out_ready), .in_data(d_out_pkt),
        .out_valid(e_valid), .out_ready(e_ready), .out_data(e_pkt)
    );

    gpr_file u_gpr (
        .clk(clk), .rst(rst),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(retire_we), .rd(retire_rd), .wdata(retire_data)
    );

    // The trapping pc is the pc of the ecall that retires
    csr_file u_csr (
        .clk(clk), .rst(rst),
        .addr(csr_addr), .rdata(csr_rdata), .we(csr_we), .wdata(csr_wdata),
        .trap(csr_trap), .trap_pc(retire_pc), .mtvec(csr_mtvec), .mepc(csr_mepc)
    );

    exec_unit u_exec (
        .clk(clk), .rst(rst),
        .in_valid(e_valid), .in_ready(e_ready), .in_pkt(e_pkt),
        .gpr_we(retire_we), .gpr_rd(retire_rd), .gpr_wdata(retire_data),
        .csr_addr(csr_addr), .csr_rdata(csr_rdata), .csr_we(csr_we),
        .csr_wdata(csr_wdata), .csr_trap(csr_trap),
        .csr_mtvec(csr_mtvec), .csr_mepc(csr_mepc),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .illegal(illegal), .halt(halt)
    );

endmodule

`default_nettype wire

// File: rv_core_props.sv
`default_nettype none

module rv_core_props
    import rv_pkg::*;
(
    input wire        clk,
    input wire        rst,
    input wire word_t imem_addr,
    input wire        retire_valid,
    input wire word_t retire_pc,
    input wire        halt,
    input wire        redirect,
    input wire word_t redirect_pc
);

    logic  armed;
    word_t fall_pc;
    word_t target_pc;

    // Remember the fall-through and target of the last redirect until the next retire
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (redirect) begin
            armed     <= 1'b1;
            fall_pc   <= retire_pc + 32'd4;
            target_pc <= redirect_pc;
        end else if (retire_valid) begin
            armed <= 1'b0;
        end
    end

    assert property (@(posedge clk) rst |-> !retire_valid)
        else $error("retire_valid high during reset");

    // A halted core neither retires nor moves its fetch address
    assert property (@(posedge clk) disable iff (rst)
        halt |=> !retire_valid && $stable(imem_addr))
        else $error("core still active after halt");

    assert property (@(posedge clk) disable iff (rst)
        armed && retire_valid |-> (retire_pc != fall_pc) || (retire_pc == target_pc))
        else $error("wrong-path instruction retired after a redirect");

endmodule

bind rv_core rv_core_props u_props (
    .clk(clk),
    .rst(rst),
    .imem_addr(imem_addr),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .halt(halt),
    .redirect(redirect),
    .redirect_pc(redirect_pc)
);

`default_nettype wire

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    localparam int retire_timeout = 200;
    localparam int halt_timeout   = 50;

    logic     clk;
    logic     rst;
    word_t    imem_addr;
    word_t    imem_data;
    logic     imem_valid;
    logic     retire_valid;
    word_t    retire_pc;
    reg_idx_t retire_rd;
    logic     retire_we;
    word_t    retire_data;
    logic     illegal;
    logic     halt;

    word_t    prog_mem [64];
    logic     prog_ok [64];
    string    exp_name [$];
    word_t    exp_pc [$];
    reg_idx_t exp_rd [$];
    logic     exp_we [$];
    word_t    exp_data [$];
    logic     exp_ill [$];
    logic     expect_halt;
    logic     stim_ok;
    int       value_errors;
    int       other_errors;
    int       timeouts;

    rv_core uut (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_data(imem_data), .imem_valid(imem_valid),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_data(retire_data),
        .illegal(illegal), .halt(halt)
    );

    always #4 clk = ~clk;

    // Words outside the program read as the illegal word 0
    assign imem_data = (imem_addr[31:8] == 24'd0 && prog_ok[imem_addr[7:2]]) ?
                       prog_mem[imem_addr[7:2]] : 32'd0;

    initial begin
        void'($urandom(32'h5d930f99));
        forever begin
            @(posedge clk);
            imem_valid <= !rst && ($urandom % 4 != 0);
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %0d, got %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %b, got %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        int    i;
        string tag;
        string name;
        string rest;
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        stim_ok     = 1'b0;
        expect_halt = 1'b0;
        for (i = 0; i < 64; i++) begin
            prog_mem[i] = '0;
            prog_ok[i]  = 1'b0;
        end
        fd = $fopen("rv_core_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open rv_core_stim.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) break;
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "I") begin
                n = $fscanf(fd, "%h %h", a, b);
                prog_mem[a[7:2]] = b;
                prog_ok[a[7:2]]  = 1'b1;
            end else if (tag == "E" || tag == "X") begin
                b = '0;
                c = '0;
                d = '0;
                if (tag == "E") begin
                    n = $fscanf(fd, "%s %h %h %h %h", name, a, b, c, d);
                end else begin
                    n = $fscanf(fd, "%s %h", name, a);
                end
                exp_name.push_back(name);
                exp_pc.push_back(a);
                exp_rd.push_back(b[3:0]);
                exp_we.push_back(c[0]);
                exp_data.push_back(d);
                exp_ill.push_back(tag == "X");
            end else if (tag == "H") begin
                expect_halt = 1'b1;
            end else begin
                $display("Unknown stimulus line starting with %s", tag);
                other_errors++;
            end
        end
        $fclose(fd);
        stim_ok = 1'b1;
    endtask

    task automatic wait_retire(input string name, output logic got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && !halt && cycles < retire_timeout) begin
            @(negedge clk);
            if (retire_valid) got = 1'b1;
            cycles++;
        end
        if (!got) begin
            if (halt) begin
                $display("The core halted while %s was still expected", name);
            end else begin
                $display("Timed out waiting for %s to retire", name);
            end
            timeouts++;
        end
    endtask

    task automatic compare_retire(input int i);
        check_word({exp_name[i], " pc"}, exp_pc[i], retire_pc);
        check_bit({exp_name[i], " illegal"}, exp_ill[i], illegal);
        check_bit({exp_name[i], " we"}, exp_we[i], retire_we);
        // Destination fields only mean something when a register is written
        if (exp_we[i]) begin
            check_reg({exp_name[i], " rd"}, exp_rd[i], retire_rd);
            check_word({exp_name[i], " data"}, exp_data[i], retire_data);
        end
    endtask

    task automatic watch_halt();
        int cycles;
        cycles = 0;
        while (!halt && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("Timed out waiting for the core to halt");
            timeouts++;
        end else begin
            for (cycles = 0; cycles < 20; cycles++) begin
                @(negedge clk);
                if (retire_valid) begin
                    $display("An instruction retired at pc %h after the halt", retire_pc);
                    other_errors++;
                end
            end
        end
    endtask

    initial begin
        logic got;
        int   i;
        clk          = 1'b0;
        rst          = 1'b1;
        imem_valid   = 1'b0;
        value_errors = 0;
        other_errors = 0;
        timeouts     = 0;
        got          = 1'b1;
        load_stim();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_word("reset imem_addr", reset_vector, imem_addr);
        check_bit("reset retire_valid", 1'b0, retire_valid);
        check_bit("reset halt", 1'b0, halt);
        @(posedge clk);
        rst <= 1'b0;
        if (stim_ok) begin
            for (i = 0; i < exp_pc.size() && got; i++) begin
                wait_retire(exp_name[i], got);
                if (got) compare_retire(i);
            end
            if (expect_halt && got) watch_halt();
        end
        $display("Errors: %0d wrong values, %0d other failures, %0d timeouts",
                 value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core_stim.txt
# I addr word : program word at a byte address
# E name pc rd we data : expected retire, X name pc : illegal retire, H : halt
I 00 00500093
I 04 ffd00113
I 08 002081b3
I 0c 40208233
I 10 001122b3
I 14 00113333
I 18 0f014393
I 1c 00409413
I 20 40115493
I 24 01c15513
I 28 123455b7
I 2c 00001617
I 30 00a5e6b3
I 34 0076f733
I 38 00108463
I 3c 00100793
I 40 00109463
I 44 00c000ef
I 48 00200793
I 4c 00300793
I 50 01108767
I 54 00400793
I 58 00114463
I 5c 00500793
I 60 00116463
I 64 0020d463
I 68 00600793
I 6c 09000313
I 70 305312f3
I 74 305023f3
I 78 00000073
I 7c 00700793
I 80 ffffffff
I 84 00100813
I 88 00100073
I 8c 00800793
I 90 34102473
I 94 342024f3
I 98 00440413
I 9c 34141073
I a0 30200073
I a4 00900793
E addi_x1 00 1 1 00000005
E addi_x2 04 2 1 fffffffd
E add_dep 08 3 1 00000002
E sub 0c 4 1 00000008
E slt 10 5 1 00000001
E sltu 14 6 1 00000000
E xori 18 7 1 ffffff0d
E slli 1c 8 1 00000050
E srai 20 9 1 fffffffe
E srli 24 a 1 0000000f
E lui 28 b 1 12345000
E auipc 2c c 1 0000102c
E or 30 d 1 1234500f
E and_dep 34 e 1 1234500d
E beq_taken 38 0 0 0
E bne_fall 40 0 0 0
E jal 44 1 1 00000048
E jalr 50 e 1 00000054
E blt_taken 58 0 0 0
E bltu_fall 60 0 0 0
E bge_taken 64 0 0 0
E addi_x6 6c 6 1 00000090
E csrrw_mtvec 70 5 1 00000000
E csrrs_mtvec 74 7 1 00000090
E ecall 78 0 0 0
E csrrs_mepc 90 8 1 00000078
E csrrs_mcause 94 9 1 0000000b
E addi_mepc 98 8 1 0000007c
E csrrw_mepc 9c 0 1 00000078
E mret a0 0 0 0
E addi_x15 7c f 1 00000007
X bad_word 80
X bad_reg 84
E ebreak 88 0 0 0
H

// File: sources.f
rv_pkg.sv
pipe_stage.sv
fetch_unit.sv
decode_unit.sv
gpr_file.sv
csr_file.sv
exec_unit.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv
